//--- Bender.yml
package:
  name: cache

sources:
  - cache_pkg.sv
  - way_ram.sv
  - dirty_array.sv
  - victim_lfsr.sv
  - hit_select.sv
  - cache_ctrl.sv
  - cache_top.sv
  - target: simulation
    files:
      - tb_cache.sv

//--- cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
	input  logic                 clk,
	input  logic                 resetn,
	// pipeline side
	input  logic                 valid,
	input  logic                 op,
	input  cache_pkg::index_t    index,
	input  cache_pkg::tag_t      tag,
	input  cache_pkg::offset_t   offset,
	input  cache_pkg::strb_t     wstrb,
	input  cache_pkg::word_t     wdata,
	output logic                 addr_ok,
	output logic                 data_ok,
	output cache_pkg::word_t     rdata,
	// bridge side
	output logic                 rd_req,
	output logic [31:0]          rd_addr,
	input  logic                 rd_rdy,
	input  logic                 ret_valid,
	input  logic                 ret_last,
	input  cache_pkg::word_t     ret_data,
	output logic                 wr_req,
	output logic [31:0]          wr_addr,
	input  logic                 wr_rdy,
	// lookup inputs
	input  logic                 victim_way,
	input  logic                 hit,
	input  logic                 hit_way,
	input  cache_pkg::word_t     load_word,
	input  cache_pkg::tagv_t     way0_tagv,
	input  cache_pkg::tagv_t     way1_tagv,
	input  logic                 way0_dirty,
	input  logic                 way1_dirty,
	// store control
	output cache_pkg::index_t    ram_addr,
	output logic [1:0]           tagv_we,
	output cache_pkg::tagv_t     tagv_wdata,
	output logic [7:0]           bank_we,
	output cache_pkg::word_t     bank_wdata,
	output logic [1:0]           dirty_we,
	output logic                 dirty_wdata,
	output cache_pkg::tag_t      req_tag,
	output cache_pkg::bank_sel_t bank_sel,
	output logic                 repl_way
);

	import cache_pkg::*;

	state_t    state;
	state_t    state_next;
	logic      accept;
	logic      wb_need;
	tag_t      wr_tag;
	bank_sel_t refill_cnt;

	// request buffer
	logic      req_op;
	index_t    req_index;
	strb_t     req_wstrb;
	word_t     req_wdata;

	// byte-wise merge of store data over an old word
	function automatic word_t merge_word(word_t old_w, word_t new_w, strb_t strb);
		word_t res;
		res = old_w;
		for (int i = 0; i < 4; i++)
			if (strb[i])
				res[i*8 +: 8] = new_w[i*8 +: 8];
		return res;
	endfunction

	// only one request in flight, so accept only while idle
	assign addr_ok = (state == IDLE);
	assign accept  = addr_ok && valid;

	// incoming index feeds the rams in the accept cycle
	assign ram_addr = (state == IDLE) ? index : req_index;

	// chosen victim needs write-back when valid and dirty
	assign wb_need = victim_way ? (way1_tagv.valid && way1_dirty)
	                            : (way0_tagv.valid && way0_dirty);

	// line-aligned bridge addresses
	assign wr_tag  = repl_way ? way1_tagv.tag : way0_tagv.tag;
	assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};
	assign wr_addr = {wr_tag, req_index, {OFFSET_W{1'b0}}};

	// next state
	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
				if (valid)
					state_next = LOOKUP;
			LOOKUP:
				state_next = hit ? IDLE : MISS;
			// hold here until the write-back is taken
			MISS:
				if (!wr_req || wr_rdy)
					state_next = REPLACE;
			REPLACE:
				if (rd_req && rd_rdy)
					state_next = REFILL;
			REFILL:
				if (ret_valid && ret_last)
					state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	// control state
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state      <= IDLE;
			data_ok    <= 1'b0;
			wr_req     <= 1'b0;
			rd_req     <= 1'b0;
			repl_way   <= 1'b0;
			refill_cnt <= '0;
		end
		else
		begin
			state <= state_next;
			// one pulse, hit or last refill beat
			data_ok <= (state == LOOKUP && hit) || (state == REFILL && ret_valid && ret_last);
			// victim latched at lookup to miss
			if (state == LOOKUP && !hit)
				repl_way <= victim_way;
			// write-back raised on entry to miss
			if (state == LOOKUP && !hit)
				wr_req <= wb_need;
			else if (wr_rdy)
				wr_req <= 1'b0;
			// refill read follows the write-back
			if (state == MISS && state_next == REPLACE)
				rd_req <= 1'b1;
			else if (rd_rdy)
				rd_req <= 1'b0;
			// beats come back word 0 first
			if (state == REPLACE)
				refill_cnt <= '0;
			else if (state == REFILL && ret_valid)
				refill_cnt <= refill_cnt + 2'd1;
		end
	end

	// request buffer, loaded on accept
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_op    <= op;
			req_tag   <= tag;
			req_index <= index;
			bank_sel  <= offset[OFFSET_W-1 -: 2];
			req_wstrb <= wstrb;
			req_wdata <= wdata;
		end
	end

	// load data, held until the next load completes
	always_ff @(posedge clk)
	begin
		if (state == LOOKUP && hit && !req_op)
			rdata <= load_word;
		else if (state == REFILL && ret_valid && !req_op && refill_cnt == bank_sel)
			rdata <= ret_data;
	end

	// ram write control
	always_comb
	begin
		tagv_we          = '0;
		tagv_wdata.tag   = req_tag;
		tagv_wdata.valid = 1'b1;
		bank_we          = '0;
		bank_wdata       = ret_data;
		dirty_we         = '0;
		dirty_wdata      = req_op;
		if (state == LOOKUP && hit && req_op)
		begin
			// store hit, merge into the hitting word
			bank_we[{hit_way, bank_sel}] = 1'b1;
			bank_wdata                   = merge_word(load_word, req_wdata, req_wstrb);
			dirty_we[hit_way]            = 1'b1;
		end
		else if (state == REFILL && ret_valid)
		begin
			bank_we[{repl_way, refill_cnt}] = 1'b1;
			// store miss lands on its word as it arrives
			if (req_op && refill_cnt == bank_sel)
				bank_wdata = merge_word(ret_data, req_wdata, req_wstrb);
			// last beat validates the line, dirty only for a store
			if (ret_last)
			begin
				tagv_we[repl_way]  = 1'b1;
				dirty_we[repl_way] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- cache_pkg.sv
`default_nettype none

package cache_pkg;

	// cache geometry
	localparam int NUM_WAYS       = 2;
	localparam int NUM_SETS       = 256;
	localparam int WORDS_PER_LINE = 4;

	// address split, tag | index | offset
	localparam int TAG_W    = 20;
	localparam int INDEX_W  = 8;
	localparam int OFFSET_W = 4;

	// victim lfsr start value, must be nonzero
	localparam logic [22:0] LFSR_SEED = 23'h5500ff;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;

	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [OFFSET_W-1:0] offset_t;

	// word number, top two offset bits
	typedef logic [1:0] bank_sel_t;

	// word 0 sits in the low bits
	typedef word_t [WORDS_PER_LINE-1:0] line_t;

	// valid lands in bit 0
	typedef struct packed {
		tag_t tag;
		logic valid;
	} tagv_t;

	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		LOOKUP  = 3'd1,
		MISS    = 3'd2,
		REPLACE = 3'd3,
		REFILL  = 3'd4
	} state_t;

endpackage

`default_nettype wire

//--- cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
	input  logic               clk,
	input  logic               resetn,
	// pipeline side
	input  logic               valid,
	input  logic               op,
	input  cache_pkg::index_t  index,
	input  cache_pkg::tag_t    tag,
	input  cache_pkg::offset_t offset,
	input  cache_pkg::strb_t   wstrb,
	input  cache_pkg::word_t   wdata,
	output logic               addr_ok,
	output logic               data_ok,
	output cache_pkg::word_t   rdata,
	// bridge read
	output logic               rd_req,
	output logic [31:0]        rd_addr,
	input  logic               rd_rdy,
	input  logic               ret_valid,
	input  logic               ret_last,
	input  cache_pkg::word_t   ret_data,
	// bridge write
	output logic               wr_req,
	output logic [31:0]        wr_addr,
	output cache_pkg::line_t   wr_data,
	input  logic               wr_rdy
);

	import cache_pkg::*;

	// shared ram control from the controller
	index_t     ram_addr;
	logic [1:0] tagv_we;
	tagv_t      tagv_wdata;
	logic [7:0] bank_we;
	word_t      bank_wdata;
	logic [1:0] dirty_we;
	logic       dirty_wdata;

	// per-way read side
	wire tagv_t way_tagv [NUM_WAYS];
	wire line_t way_line [NUM_WAYS];
	wire        way_dirty [NUM_WAYS];

	logic      victim_way;
	logic      hit;
	logic      hit_way;
	word_t     load_word;
	tag_t      req_tag;
	bank_sel_t bank_sel;
	logic      repl_way;

	// victim line out to the bridge, held by the idle rams during miss
	assign wr_data = repl_way ? way_line[1] : way_line[0];

	for (genvar w = 0; w < NUM_WAYS; w++)
	begin : g_way
		way_ram #(.payload_t(tagv_t)) i_tagv (
			.clk   (clk),
			.addr  (ram_addr),
			.we    (tagv_we[w]),
			.wdata (tagv_wdata),
			.rdata (way_tagv[w])
		);

		dirty_array i_dirty (
			.clk    (clk),
			.resetn (resetn),
			.addr   (ram_addr),
			.we     (dirty_we[w]),
			.wdata  (dirty_wdata),
			.rdata  (way_dirty[w])
		);

		// one word bank per ram, bank_we is way-major
		for (genvar b = 0; b < WORDS_PER_LINE; b++)
		begin : g_bank
			way_ram #(.payload_t(word_t)) i_bank (
				.clk   (clk),
				.addr  (ram_addr),
				.we    (bank_we[w*WORDS_PER_LINE + b]),
				.wdata (bank_wdata),
				.rdata (way_line[w][b])
			);
		end
	end

	victim_lfsr i_lfsr (
		.clk        (clk),
		.resetn     (resetn),
		.victim_way (victim_way)
	);

	hit_select i_hit (
		.req_tag   (req_tag),
		.bank_sel  (bank_sel),
		.way0_tagv (way_tagv[0]),
		.way1_tagv (way_tagv[1]),
		.way0_line (way_line[0]),
		.way1_line (way_line[1]),
		.hit       (hit),
		.hit_way   (hit_way),
		.load_word (load_word)
	);

	cache_ctrl i_ctrl (
		.clk         (clk),
		.resetn      (resetn),
		.valid       (valid),
		.op          (op),
		.index       (index),
		.tag         (tag),
		.offset      (offset),
		.wstrb       (wstrb),
		.wdata       (wdata),
		.addr_ok     (addr_ok),
		.data_ok     (data_ok),
		.rdata       (rdata),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.rd_rdy      (rd_rdy),
		.ret_valid   (ret_valid),
		.ret_last    (ret_last),
		.ret_data    (ret_data),
		.wr_req      (wr_req),
		.wr_addr     (wr_addr),
		.wr_rdy      (wr_rdy),
		.victim_way  (victim_way),
		.hit         (hit),
		.hit_way     (hit_way),
		.load_word   (load_word),
		.way0_tagv   (way_tagv[0]),
		.way1_tagv   (way_tagv[1]),
		.way0_dirty  (way_dirty[0]),
		.way1_dirty  (way_dirty[1]),
		.ram_addr    (ram_addr),
		.tagv_we     (tagv_we),
		.tagv_wdata  (tagv_wdata),
		.bank_we     (bank_we),
		.bank_wdata  (bank_wdata),
		.dirty_we    (dirty_we),
		.dirty_wdata (dirty_wdata),
		.req_tag     (req_tag),
		.bank_sel    (bank_sel),
		.repl_way    (repl_way)
	);

endmodule

`default_nettype wire

//--- dirty_array.sv
`timescale 1ns/1ps
`default_nettype none

module dirty_array (
	input  logic              clk,
	input  logic              resetn,
	input  cache_pkg::index_t addr,
	input  logic              we,
	input  logic              wdata,
	output logic              rdata
);

	import cache_pkg::*;

	// one flag per set, kept in flops
	logic [NUM_SETS-1:0] dirty;

	// all lines clean after reset
	always_ff @(posedge clk)
	begin
		if (!resetn)
			dirty <= '0;
		else if (we)
			dirty[addr] <= wdata;
	end

	// combinational read, same cycle as addr
	assign rdata = dirty[addr];

endmodule

`default_nettype wire

//--- hit_select.sv
`timescale 1ns/1ps
`default_nettype none

module hit_select (
	input  cache_pkg::tag_t      req_tag,
	input  cache_pkg::bank_sel_t bank_sel,
	input  cache_pkg::tagv_t     way0_tagv,
	input  cache_pkg::tagv_t     way1_tagv,
	input  cache_pkg::line_t     way0_line,
	input  cache_pkg::line_t     way1_line,
	output logic                 hit,
	output logic                 hit_way,
	output cache_pkg::word_t     load_word
);

	import cache_pkg::*;

	logic  way0_hit;
	logic  way1_hit;
	word_t way0_word;
	word_t way1_word;

	// tag compare, only valid entries count
	assign way0_hit = way0_tagv.valid && (way0_tagv.tag == req_tag);
	assign way1_hit = way1_tagv.valid && (way1_tagv.tag == req_tag);

	assign hit = way0_hit || way1_hit;

	// a line lives in at most one way
	// so way 1 hitting names the way outright
	assign hit_way = way1_hit;

	// requested word from each way
	assign way0_word = way0_line[bank_sel];
	assign way1_word = way1_line[bank_sel];

	// load result, also the old word for a store merge
	assign load_word = hit_way ? way1_word : way0_word;

endmodule

`default_nettype wire

//--- list.f
cache_pkg.sv
way_ram.sv
dirty_array.sv
victim_lfsr.sv
hit_select.sv
cache_ctrl.sv
cache_top.sv
tb_cache.sv

//--- tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

	import cache_pkg::*;

	localparam int CLK_PERIOD      = 8;
	localparam int NUM_RAND        = 300;
	localparam int TOTAL_REQS      = 40 + NUM_RAND;
	localparam int WATCHDOG_CYCLES = TOTAL_REQS * 60 + 200;

	logic        clk = 1'b0;
	logic        resetn;
	logic        valid;
	logic        op;
	index_t      index;
	tag_t        tag;
	offset_t     offset;
	strb_t       wstrb;
	word_t       wdata;
	logic        addr_ok;
	logic        data_ok;
	word_t       rdata;
	logic        rd_req;
	logic [31:0] rd_addr;
	logic        rd_rdy;
	logic        ret_valid;
	logic        ret_last;
	word_t       ret_data;
	logic        wr_req;
	logic [31:0] wr_addr;
	line_t       wr_data;
	logic        wr_rdy;

	// bridge memory and the expected view of the whole address space
	word_t       mem    [logic [31:0]];
	word_t       mirror [logic [31:0]];
	// one entry per accepted request, popped at its data_ok
	word_t       exp_q [$];
	logic        op_q  [$];
	int          cyc_q [$];
	logic        hit_q [$];
	logic [31:0] exp_line;
	logic        clean_phase = 1'b0;
	int          cyc = 0;
	int          errors = 0;
	int          load_checks = 0;
	int          accepts = 0;
	int          rd_count = 0;
	int          wb_count = 0;

	cache_top i_dut (.*);

	initial
		forever #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// unwritten memory pattern, word address xor a marker
	function automatic word_t init_word(logic [31:0] addr);
		return {2'b00, addr[31:2]} ^ 32'h5a5a0000;
	endfunction

	// reference: expected contents of an aligned word
	function automatic word_t ref_load(logic [31:0] addr);
		if (mirror.exists(addr))
			return mirror[addr];
		return init_word(addr);
	endfunction

	// byte lanes selected by the strobes take the new data
	function automatic word_t merge_strobes(word_t old_w, word_t new_w, strb_t s);
		word_t mask;
		mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	function automatic word_t mem_read(logic [31:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return init_word(addr);
	endfunction

	task automatic check_reset_outputs();
		assert (!rd_req && !wr_req && !data_ok && addr_ok)
		else
		begin
			errors++;
			$display("ERROR at %0t: outputs after reset rd_req=%b wr_req=%b data_ok=%b addr_ok=%b",
				$time, rd_req, wr_req, data_ok, addr_ok);
		end
	endtask

	// called right after a falling edge, returns one falling edge after accept
	task automatic do_req(input logic st, input tag_t t, input index_t ix, input offset_t off,
		input strb_t s, input word_t d, input logic expect_hit);
		logic [31:0] waddr;
		waddr  = {t, ix, off[3:2], 2'b00};
		valid  = 1'b1;
		op     = st;
		tag    = t;
		index  = ix;
		offset = off;
		wstrb  = s;
		wdata  = d;
		// accept happens at the next rising edge once addr_ok is seen
		while (!addr_ok)
			@(negedge clk);
		exp_line = {t, ix, 4'h0};
		exp_q.push_back(ref_load(waddr));
		op_q.push_back(st);
		cyc_q.push_back(cyc);
		hit_q.push_back(expect_hit);
		if (st)
			mirror[waddr] = merge_strobes(ref_load(waddr), d, s);
		accepts++;
		@(negedge clk);
		valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	// compare at each data_ok, sampled where outputs are stable
	always @(negedge clk)
	begin
		word_t e;
		logic  o;
		int    c;
		logic  h;
		if (resetn && data_ok)
		begin
			assert (exp_q.size() > 0)
			else
			begin
				errors++;
				$display("data_ok at %0t with no request outstanding", $time);
			end
			if (exp_q.size() > 0)
			begin
				e = exp_q.pop_front();
				o = op_q.pop_front();
				c = cyc_q.pop_front();
				h = hit_q.pop_front();
				if (!o)
				begin
					load_checks++;
					assert (rdata == e)
					else
					begin
						errors++;
						$display("ERROR at %0t: rdata expected %h got %h", $time, e, rdata);
					end
				end
				if (h)
					assert (cyc - c == 2)
					else
					begin
						errors++;
						$display("ERROR at %0t: hit latency expected 2 got %0d", $time, cyc - c);
					end
			end
		end
	end

	// bridge model, random ready delays and beat gaps
	initial
	begin
		int          delay;
		int          gap;
		logic [31:0] line;
		forever
		begin
			@(negedge clk);
			if (resetn && wr_req)
			begin
				delay = $urandom_range(0, 5);
				repeat (delay)
					@(negedge clk);
				wr_rdy = 1'b1;
				wb_count++;
				assert (!clean_phase)
				else
				begin
					errors++;
					$display("write-back at %0t while only clean lines were evicted", $time);
				end
				assert (wr_addr[3:0] == 4'h0 && wr_addr[11:4] == exp_line[11:4])
				else
				begin
					errors++;
					$display("ERROR at %0t: wr_addr expected index %h got %h",
						$time, exp_line[11:4], wr_addr);
				end
				for (int i = 0; i < WORDS_PER_LINE; i++)
				begin
					assert (wr_data[i] == ref_load(wr_addr + 32'(i * 4)))
					else
					begin
						errors++;
						$display("ERROR at %0t: wr_data[%0d] expected %h got %h",
							$time, i, ref_load(wr_addr + 32'(i * 4)), wr_data[i]);
					end
					mem[wr_addr + 32'(i * 4)] = wr_data[i];
				end
				@(negedge clk);
				wr_rdy = 1'b0;
			end
			else if (resetn && rd_req)
			begin
				delay = $urandom_range(0, 5);
				repeat (delay)
					@(negedge clk);
				rd_rdy = 1'b1;
				line   = rd_addr;
				rd_count++;
				assert (rd_addr == exp_line)
				else
				begin
					errors++;
					$display("ERROR at %0t: rd_addr expected %h got %h", $time, exp_line, rd_addr);
				end
				@(negedge clk);
				rd_rdy = 1'b0;
				// four beats, word 0 first
				for (int i = 0; i < WORDS_PER_LINE; i++)
				begin
					gap = $urandom_range(0, 2);
					repeat (gap)
					begin
						ret_valid = 1'b0;
						@(negedge clk);
					end
					ret_valid = 1'b1;
					ret_last  = (i == WORDS_PER_LINE - 1);
					ret_data  = mem_read(line + 32'(i * 4));
					@(negedge clk);
				end
				ret_valid = 1'b0;
				ret_last  = 1'b0;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, requests stopped completing", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		int      rd_before;
		int      wb_before;
		offset_t st_off;
		void'($urandom(32'h90d640ca));
		resetn    = 1'b0;
		valid     = 1'b0;
		op        = 1'b0;
		index     = '0;
		tag       = '0;
		offset    = '0;
		wstrb     = '0;
		wdata     = '0;
		rd_rdy    = 1'b0;
		ret_valid = 1'b0;
		ret_last  = 1'b0;
		ret_data  = '0;
		wr_rdy    = 1'b0;
		repeat (2)
		begin
			@(negedge clk);
			check_reset_outputs();
		end
		resetn = 1'b1;
		@(negedge clk);
		check_reset_outputs();

		// load miss, then the same line again as a hit
		rd_before = rd_count;
		do_req(1'b0, 20'h00abc, 8'h05, 4'h4, 4'h0, '0, 1'b0);
		wait_idle();
		assert (rd_count == rd_before + 1)
		else
		begin
			errors++;
			$display("first load miss issued %0d reads instead of one", rd_count - rd_before);
		end
		do_req(1'b0, 20'h00abc, 8'h05, 4'h4, 4'h0, '0, 1'b1);
		wait_idle();
		assert (rd_count == rd_before + 1)
		else
		begin
			errors++;
			$display("load hit issued a bridge read");
		end

		// partial stores, hits on set 5 and misses on fresh lines of set 6
		for (int i = 0; i < 4; i++)
		begin
			do_req(1'b1, 20'h00abc, 8'h05, 4'(i * 4), 4'($urandom), $urandom, 1'b0);
			do_req(1'b0, 20'h00abc, 8'h05, 4'(i * 4), 4'h0, '0, 1'b1);
			// load back the very word the store miss merged
			st_off = 4'($urandom);
			do_req(1'b1, 20'h00b00 + 20'(i), 8'h06, st_off, 4'($urandom), $urandom, 1'b0);
			do_req(1'b0, 20'h00b00 + 20'(i), 8'h06, st_off, 4'h0, '0, 1'b1);
		end
		wait_idle();

		// dirty eviction, five tags stored into one set
		wb_before = wb_count;
		for (int t = 0; t < 5; t++)
			do_req(1'b1, 20'h00100 + 20'(t), 8'h20, 4'($urandom), 4'hf, $urandom, 1'b0);
		for (int t = 0; t < 5; t++)
			do_req(1'b0, 20'h00100 + 20'(t), 8'h20, 4'($urandom), 4'h0, '0, 1'b0);
		wait_idle();
		assert (wb_count - wb_before >= 3)
		else
		begin
			errors++;
			$display("dirty evictions produced only %0d write-backs", wb_count - wb_before);
		end

		// clean eviction, loads only in a set nothing else touches
		clean_phase = 1'b1;
		for (int t = 0; t < 6; t++)
			do_req(1'b0, 20'h00200 + 20'(t % 4), 8'h40, 4'($urandom), 4'h0, '0, 1'b0);
		wait_idle();
		clean_phase = 1'b0;

		// random mixed traffic over four sets and four tags
		for (int n = 0; n < NUM_RAND; n++)
			do_req(1'($urandom), 20'h00300 + 20'($urandom_range(0, 3)),
				8'h10 + 8'($urandom_range(0, 3)), 4'($urandom), 4'($urandom), $urandom, 1'b0);
		wait_idle();
		repeat (4)
			@(negedge clk);
		assert (exp_q.size() == 0 && !data_ok)
		else
		begin
			errors++;
			$display("requests left without data_ok or extra data_ok seen at the end");
		end

		$display("errors=%0d load_checks=%0d requests=%0d reads=%0d write_backs=%0d",
			errors, load_checks, accepts, rd_count, wb_count);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- victim_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

module victim_lfsr (
	input  logic clk,
	input  logic resetn,
	output logic victim_way
);

	import cache_pkg::*;

	logic [$bits(LFSR_SEED)-1:0] lfsr;

	// fibonacci form, taps 22 and 17
	// shifts every cycle, whether a miss is pending or not
	always_ff @(posedge clk)
	begin
		if (!resetn)
			lfsr <= LFSR_SEED;
		else
			lfsr <= {lfsr[21:0], lfsr[22] ^ lfsr[17]};
	end

	// low bit picks the way
	assign victim_way = lfsr[0];

endmodule

`default_nettype wire

//--- way_ram.sv
`timescale 1ns/1ps
`default_nettype none

module way_ram #(
	parameter type payload_t = cache_pkg::word_t
) (
	input  logic              clk,
	input  cache_pkg::index_t addr,
	input  logic              we,
	input  payload_t          wdata,
	output payload_t          rdata
);

	import cache_pkg::*;

	// one entry per set
	payload_t mem [NUM_SETS];

	// ram powers up all zero, so every tag starts invalid
	initial
	begin
		for (int i = 0; i < NUM_SETS; i++)
			mem[i] = '0;
	end

	// write port
	always @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
	end

	// registered read, data one cycle after addr
	// read before write on a collision
	always_ff @(posedge clk)
	begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire
